//--- mem_bus_pkg.sv
// ==================================================
// Bus widths and byte write mask for the memory path
// Word is two bytes, so BITS must be even
// Top address bit selects the memory bank
// ==================================================

package mem_bus_pkg;

	// Data word width
	localparam int BITS_DEFAULT = 16;

	// Word address width, bank select in the top bit
	localparam int ADDRESS_BITS_DEFAULT = 15;

	// One enable per byte lane, bit 1 is the upper byte
	typedef logic [1:0] wr_mask_t;

	// All-zero mask writes the whole word
	localparam wr_mask_t WR_MASK_ALL = 2'b00;

	// Lane positions inside wr_mask_t
	localparam int LANE_LO = 0;
	localparam int LANE_HI = 1;

endpackage

//--- mem_arb_pkg.sv
// ==================================================
// Arbiter FSM encoding and requester identifiers
// Shared by the arbiter and its checkers
// ==================================================

package mem_arb_pkg;

	// Arbiter FSM states
	typedef enum logic [1:0] {
		// No requests, bank released
		st_idle         = 2'd0,
		// Valid raised, waiting for rdy
		st_request_bank = 2'd1,
		// Bank open, pipeline running
		st_execute      = 2'd2,
		// One cycle with the bank released
		st_bank_switch  = 2'd3
	} arb_state_t;

	// Owner of a pipeline slot
	typedef enum logic {
		req_data  = 1'b0,
		req_instr = 1'b1
	} req_id_t;

endpackage

//--- fetch_unit.sv
// ==================================================
// Sequential instruction fetch
// Request is held until a success with matching address
// Duplicate or stale successes are ignored
// ==================================================

`timescale 1ns/1ps

module fetch_unit import mem_bus_pkg::*; #(
	parameter int BITS         = BITS_DEFAULT,
	parameter int ADDRESS_BITS = ADDRESS_BITS_DEFAULT
) (
	input  logic                    CLK,
	input  logic                    RSTb,

	// Control
	input  logic                    fetch_en,
	input  logic [ADDRESS_BITS-1:0] start_address,

	// Request towards the arbiter
	output logic [ADDRESS_BITS-1:0] fetch_address,
	output logic                    fetch_read_req,

	// Return from the arbiter
	input  logic [BITS-1:0]         instruction_data,
	input  logic [ADDRESS_BITS-1:0] instruction_address_out,
	input  logic                    instruction_success,

	// Fetched instruction stream
	output logic [BITS-1:0]         fetch_word,
	output logic [ADDRESS_BITS-1:0] fetch_addr,
	output logic                    fetch_valid
);

	// Program counter
	logic [ADDRESS_BITS-1:0] pc;

	// Success for the address we are waiting on
	logic hit;

	// Arbiter may return the same address twice,
	// only the one matching pc counts
	assign hit = fetch_en && instruction_success && (instruction_address_out == pc);

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			pc <= '0;
		end else if (!fetch_en) begin
			// Parked at the start address while disabled
			pc <= start_address;
		end else if (hit) begin
			pc <= pc + 1'b1;
		end
	end

	// Keep requesting while enabled
	assign fetch_read_req = fetch_en;

	// Look ahead on a hit so the next address is sampled at once
	assign fetch_address = hit ? pc + 1'b1 : pc;

	// Word and address straight from the success cycle
	assign fetch_word  = instruction_data;
	assign fetch_addr  = instruction_address_out;
	assign fetch_valid = hit;

endmodule

//--- cpu_memory_interface.sv
// ==================================================
// Two-stage arbiter, data path has priority over fetch
// Requesters hold requests until their success pulse
// Success comes 2 cycles after the request is sampled
// A bank change costs a release and a new bank request
// ==================================================

`timescale 1ns/1ps

module cpu_memory_interface import mem_bus_pkg::*; import mem_arb_pkg::*; #(
	parameter int BITS         = BITS_DEFAULT,
	parameter int ADDRESS_BITS = ADDRESS_BITS_DEFAULT
) (
	input  logic                    CLK,
	input  logic                    RSTb,

	// Instruction channel
	input  logic [ADDRESS_BITS-1:0] fetch_address,
	input  logic                    fetch_read_req,
	output logic [BITS-1:0]         instruction_data,
	output logic [ADDRESS_BITS-1:0] instruction_address_out,
	output logic                    instruction_success,

	// Data channel
	input  logic [ADDRESS_BITS-1:0] data_address,
	input  logic [BITS-1:0]         data_wdata,
	input  logic                    data_read_req,
	input  logic                    data_write_req,
	input  wr_mask_t                data_wr_mask,
	output logic [BITS-1:0]         data_rdata,
	output logic                    data_success,

	// High from a bank switch until the bank is open again
	output logic                    bank_sw,

	// Memory side
	output logic [ADDRESS_BITS-1:0] memory_address,
	output logic [BITS-1:0]         mem_wdata,
	output logic                    mem_wr,
	output wr_mask_t                wr_mask,
	output logic                    valid,
	input  logic [BITS-1:0]         mem_rdata,
	input  logic                    rdy
);

	arb_state_t state, next_state;

	// Stage 1, the access presented to the memory
	logic [ADDRESS_BITS-1:0] addr_s1, addr_s1_next;
	logic [BITS-1:0]         data_s1, data_s1_next;
	wr_mask_t                mask_s1, mask_s1_next;
	logic                    req_s1, req_s1_next;
	logic                    rd_s1, rd_s1_next;
	req_id_t                 id_s1, id_s1_next;

	// Stage 2, the access whose result is reported
	logic [ADDRESS_BITS-1:0] addr_s2;
	logic                    req_s2;
	req_id_t                 id_s2;

	// Stage 2 access landed in the wrong bank
	logic bank_sw_pending;

	// Current bank request follows a switch
	logic reopen;

	logic bank_change;
	logic data_req;
	logic data_in_flight;
	logic result_ok;

	// Bank select bits differ between the stages
	assign bank_change = addr_s1[ADDRESS_BITS-1] != addr_s2[ADDRESS_BITS-1];

	assign data_req = data_read_req || data_write_req;

	// Held data request already in stage 1, sampling again would duplicate it
	assign data_in_flight = req_s1 && (id_s1 == req_data);

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state           <= st_idle;
			addr_s1         <= '0;
			req_s1          <= 1'b0;
			addr_s2         <= '0;
			req_s2          <= 1'b0;
			bank_sw_pending <= 1'b0;
			reopen          <= 1'b0;
		end else begin
			state           <= next_state;
			addr_s1         <= addr_s1_next;
			req_s1          <= req_s1_next;
			// Stage 2 always follows stage 1
			addr_s2         <= addr_s1;
			req_s2          <= req_s1;
			bank_sw_pending <= (state == st_execute) && bank_change;
			// Held through the bank request after a switch
			if (state == st_bank_switch)
				reopen <= 1'b1;
			else if (state != st_request_bank)
				reopen <= 1'b0;
		end
	end

	// Stage payload, flags and owner
	always_ff @(posedge CLK) begin
		data_s1 <= data_s1_next;
		mask_s1 <= mask_s1_next;
		rd_s1   <= rd_s1_next;
		id_s1   <= id_s1_next;
		id_s2   <= id_s1;
	end

	always_comb begin
		next_state   = state;
		addr_s1_next = addr_s1;
		data_s1_next = data_s1;
		mask_s1_next = mask_s1;
		req_s1_next  = req_s1;
		rd_s1_next   = rd_s1;
		id_s1_next   = id_s1;

		case (state)
			st_idle: begin
				if (data_req || fetch_read_req)
					next_state = st_request_bank;
			end
			st_request_bank: begin
				if (rdy)
					next_state = st_execute;
			end
			st_execute: begin
				if (bank_sw_pending) begin
					// Read of the failed address opens its bank,
					// requester gets success only on its own retry
					next_state   = st_bank_switch;
					addr_s1_next = addr_s2;
					req_s1_next  = 1'b0;
					rd_s1_next   = 1'b1;
					mask_s1_next = WR_MASK_ALL;
				end else if (data_req && !data_in_flight) begin
					addr_s1_next = data_address;
					data_s1_next = data_wdata;
					mask_s1_next = data_wr_mask;
					req_s1_next  = 1'b1;
					rd_s1_next   = !data_write_req;
					id_s1_next   = req_data;
				end else if (fetch_read_req) begin
					addr_s1_next = fetch_address;
					mask_s1_next = WR_MASK_ALL;
					req_s1_next  = 1'b1;
					rd_s1_next   = 1'b1;
					id_s1_next   = req_instr;
				end else if (data_req) begin
					// Bubble while the held data access completes
					req_s1_next = 1'b0;
				end else begin
					// Address kept so the bank stays consistent
					req_s1_next = 1'b0;
					next_state  = st_idle;
				end
			end
			st_bank_switch: begin
				next_state = st_request_bank;
			end
			default: begin
				next_state = st_idle;
			end
		endcase
	end

	// Stage 1 drives the memory
	assign memory_address = addr_s1;
	assign mem_wdata      = data_s1;
	assign wr_mask        = mask_s1;

	// No write into a bank that is not open
	assign mem_wr = (state == st_execute) && rdy && req_s1 && !rd_s1 &&
		!bank_change && !bank_sw_pending;

	// Stage 2 result is good unless its bank was wrong
	assign result_ok = (state == st_execute) && req_s2 && !bank_sw_pending;

	assign instruction_success = result_ok && (id_s2 == req_instr);
	assign data_success        = result_ok && (id_s2 == req_data);

	// Read data is shared, success tells who owns it
	assign instruction_data        = mem_rdata;
	assign data_rdata              = mem_rdata;
	assign instruction_address_out = addr_s2;

	assign valid   = (state == st_request_bank) || (state == st_execute);
	assign bank_sw = (state == st_bank_switch) || ((state == st_request_bank) && reopen);

endmodule

//--- bank_memory.sv
// ==================================================
// Two-bank word memory, one array for both banks
// rdy rises BANK_OPEN_CYCLES after valid, needs >= 1
// Registered read, one cycle latency
// Byte-lane writes, zero mask writes both lanes
// ==================================================

`timescale 1ns/1ps

module bank_memory import mem_bus_pkg::*; #(
	parameter int BITS             = BITS_DEFAULT,
	parameter int ADDRESS_BITS     = ADDRESS_BITS_DEFAULT,
	parameter int BANK_OPEN_CYCLES = 2
) (
	input  logic                    CLK,
	input  logic                    RSTb,
	input  logic [ADDRESS_BITS-1:0] memory_address,
	input  logic [BITS-1:0]         mem_wdata,
	input  logic                    mem_wr,
	input  wr_mask_t                wr_mask,
	input  logic                    valid,
	output logic                    rdy,
	output logic [BITS-1:0]         mem_rdata
);

	localparam int LANE_BITS = BITS / 2;
	localparam int CNT_BITS  = $clog2(BANK_OPEN_CYCLES + 1);

	// Covers both banks
	logic [BITS-1:0] mem [2**ADDRESS_BITS];

	// Cycles since valid rose
	logic [CNT_BITS-1:0] open_cnt;

	// Per-lane write enables
	logic wr_hi;
	logic wr_lo;

	assign wr_hi = mem_wr && ((wr_mask == WR_MASK_ALL) || wr_mask[LANE_HI]);
	assign wr_lo = mem_wr && ((wr_mask == WR_MASK_ALL) || wr_mask[LANE_LO]);

	// Bank open delay
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			open_cnt <= '0;
			rdy      <= 1'b0;
		end else if (!valid) begin
			// Bank released, drop rdy next cycle
			open_cnt <= '0;
			rdy      <= 1'b0;
		end else if (open_cnt == CNT_BITS'(BANK_OPEN_CYCLES - 1)) begin
			rdy <= 1'b1;
		end else begin
			open_cnt <= open_cnt + 1'b1;
		end
	end

	// Byte-lane writes
	always_ff @(posedge CLK) begin
		if (wr_hi)
			mem[memory_address][BITS-1:LANE_BITS] <= mem_wdata[BITS-1:LANE_BITS];
		if (wr_lo)
			mem[memory_address][LANE_BITS-1:0] <= mem_wdata[LANE_BITS-1:0];
	end

	// Read every cycle, old word on a same-address write
	always_ff @(posedge CLK) begin
		mem_rdata <= mem[memory_address];
	end

endmodule

//--- memory_subsystem_top.sv
// ==================================================
// Fetch unit, arbiter and banked memory
// Data port is driven by the load/store side directly
// ==================================================

`timescale 1ns/1ps

module memory_subsystem_top import mem_bus_pkg::*; #(
	parameter int BITS             = BITS_DEFAULT,
	parameter int ADDRESS_BITS     = ADDRESS_BITS_DEFAULT,
	parameter int BANK_OPEN_CYCLES = 2
) (
	input  logic                    CLK,
	input  logic                    RSTb,

	// Instruction fetch control and stream
	input  logic                    fetch_en,
	input  logic [ADDRESS_BITS-1:0] start_address,
	output logic [BITS-1:0]         fetch_word,
	output logic [ADDRESS_BITS-1:0] fetch_addr,
	output logic                    fetch_valid,

	// Load/store port
	input  logic [ADDRESS_BITS-1:0] data_address,
	input  logic [BITS-1:0]         data_wdata,
	input  logic                    data_read_req,
	input  logic                    data_write_req,
	input  wr_mask_t                data_wr_mask,
	output logic [BITS-1:0]         data_rdata,
	output logic                    data_success,

	output logic                    bank_sw
);

	// Fetch unit to arbiter
	logic [ADDRESS_BITS-1:0] fetch_address;
	logic                    fetch_read_req;
	logic [BITS-1:0]         instruction_data;
	logic [ADDRESS_BITS-1:0] instruction_address_out;
	logic                    instruction_success;

	// Arbiter to memory
	logic [ADDRESS_BITS-1:0] memory_address;
	logic [BITS-1:0]         mem_wdata;
	logic [BITS-1:0]         mem_rdata;
	logic                    mem_wr;
	wr_mask_t                wr_mask;
	logic                    valid;
	logic                    rdy;

	fetch_unit #(
		.BITS         (BITS),
		.ADDRESS_BITS (ADDRESS_BITS)
	) u_fetch (
		.CLK                     (CLK),
		.RSTb                    (RSTb),
		.fetch_en                (fetch_en),
		.start_address           (start_address),
		.fetch_address           (fetch_address),
		.fetch_read_req          (fetch_read_req),
		.instruction_data        (instruction_data),
		.instruction_address_out (instruction_address_out),
		.instruction_success     (instruction_success),
		.fetch_word              (fetch_word),
		.fetch_addr              (fetch_addr),
		.fetch_valid             (fetch_valid)
	);

	cpu_memory_interface #(
		.BITS         (BITS),
		.ADDRESS_BITS (ADDRESS_BITS)
	) u_arb (
		.CLK                     (CLK),
		.RSTb                    (RSTb),
		.fetch_address           (fetch_address),
		.fetch_read_req          (fetch_read_req),
		.instruction_data        (instruction_data),
		.instruction_address_out (instruction_address_out),
		.instruction_success     (instruction_success),
		.data_address            (data_address),
		.data_wdata              (data_wdata),
		.data_read_req           (data_read_req),
		.data_write_req          (data_write_req),
		.data_wr_mask            (data_wr_mask),
		.data_rdata              (data_rdata),
		.data_success            (data_success),
		.bank_sw                 (bank_sw),
		.memory_address          (memory_address),
		.mem_wdata               (mem_wdata),
		.mem_wr                  (mem_wr),
		.wr_mask                 (wr_mask),
		.valid                   (valid),
		.mem_rdata               (mem_rdata),
		.rdy                     (rdy)
	);

	bank_memory #(
		.BITS             (BITS),
		.ADDRESS_BITS     (ADDRESS_BITS),
		.BANK_OPEN_CYCLES (BANK_OPEN_CYCLES)
	) u_mem (
		.CLK            (CLK),
		.RSTb           (RSTb),
		.memory_address (memory_address),
		.mem_wdata      (mem_wdata),
		.mem_wr         (mem_wr),
		.wr_mask        (wr_mask),
		.valid          (valid),
		.rdy            (rdy),
		.mem_rdata      (mem_rdata)
	);

endmodule

//--- tb_memory_subsystem_asserts.sv
// ==================================================
// Arbiter protocol checks, bound into every arbiter
// Inactive while RSTb is low
// fail_count is read by the testbench at the end
// ==================================================

`timescale 1ns/1ps

module tb_memory_subsystem_asserts import mem_arb_pkg::*; (
	input logic       CLK,
	input logic       RSTb,
	input arb_state_t state,
	input logic       bank_sw,
	input logic       instruction_success,
	input logic       data_success,
	input logic       mem_wr,
	input logic       valid,
	input logic       rdy
);

	// Number of failed assertions
	int fail_count = 0;

	// No result while the bank is being reopened
	no_success_in_switch: assert property (@(posedge CLK) disable iff (!RSTb)
		bank_sw |-> !(instruction_success || data_success))
	else begin
		fail_count++;
		$error("success reported while bank_sw is high");
	end

	// Writes only into an open bank
	write_needs_open_bank: assert property (@(posedge CLK) disable iff (!RSTb)
		mem_wr |-> (valid && rdy))
	else begin
		fail_count++;
		$error("mem_wr without valid and rdy");
	end

	// Shared read data has a single owner
	one_success_at_a_time: assert property (@(posedge CLK) disable iff (!RSTb)
		!(instruction_success && data_success))
	else begin
		fail_count++;
		$error("both success signals high");
	end

	// Memory keeps the bank open while the pipeline runs
	execute_keeps_rdy: assert property (@(posedge CLK) disable iff (!RSTb)
		(state == st_execute) |-> rdy)
	else begin
		fail_count++;
		$error("rdy low in the execute state");
	end

endmodule

bind cpu_memory_interface tb_memory_subsystem_asserts u_asserts (
	.CLK                 (CLK),
	.RSTb                (RSTb),
	.state               (state),
	.bank_sw             (bank_sw),
	.instruction_success (instruction_success),
	.data_success        (data_success),
	.mem_wr              (mem_wr),
	.valid               (valid),
	.rdy                 (rdy)
);

//--- tb_memory_subsystem.sv
// ==================================================
// Directed testbench, acts as the load/store unit
// Inputs change on the falling edge only
// Fetch tests assume preloaded words in bank 0
// ==================================================

`timescale 1ns/1ps

module tb_memory_subsystem import mem_bus_pkg::*; ();

	localparam int BITS        = BITS_DEFAULT;
	localparam int AW          = ADDRESS_BITS_DEFAULT;
	localparam int LANE        = BITS / 2;
	localparam int N_TESTS     = 6;
	localparam int TEST_CYCLES = 3000;
	localparam int REQ_TIMEOUT = 64;

	logic            CLK;
	logic            RSTb;
	logic            fetch_en;
	logic [AW-1:0]   start_address;
	logic [BITS-1:0] fetch_word;
	logic [AW-1:0]   fetch_addr;
	logic            fetch_valid;
	logic [AW-1:0]   data_address;
	logic [BITS-1:0] data_wdata;
	logic            data_read_req;
	logic            data_write_req;
	wr_mask_t        data_wr_mask;
	logic [BITS-1:0] data_rdata;
	logic            data_success;
	logic            bank_sw;

	// Expected memory contents
	logic [BITS-1:0] model [2**AW];
	int check_errors;
	int other_errors;
	logic bank_sw_seen;

	initial CLK = 1'b0;
	always #4 CLK = ~CLK;

	// Sticky, cleared by the tests that look at it
	always @(negedge CLK) begin
		if (bank_sw)
			bank_sw_seen = 1'b1;
	end

	memory_subsystem_top #(
		.BITS             (BITS),
		.ADDRESS_BITS     (AW),
		.BANK_OPEN_CYCLES (2)
	) u_dut (
		.CLK            (CLK),
		.RSTb           (RSTb),
		.fetch_en       (fetch_en),
		.start_address  (start_address),
		.fetch_word     (fetch_word),
		.fetch_addr     (fetch_addr),
		.fetch_valid    (fetch_valid),
		.data_address   (data_address),
		.data_wdata     (data_wdata),
		.data_read_req  (data_read_req),
		.data_write_req (data_write_req),
		.data_wr_mask   (data_wr_mask),
		.data_rdata     (data_rdata),
		.data_success   (data_success),
		.bank_sw        (bank_sw)
	);

	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			check_errors++;
			$display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// One data access, request held until data_success
	task automatic access(input string name, input logic wr, input logic [AW-1:0] addr,
		input logic [BITS-1:0] wdata, input wr_mask_t mask);
		int cycles;
		@(negedge CLK);
		data_address   = addr;
		data_wdata     = wdata;
		data_wr_mask   = mask;
		data_write_req = wr;
		data_read_req  = !wr;
		cycles = 0;
		do begin
			@(negedge CLK);
			cycles++;
		end while (!data_success && cycles < REQ_TIMEOUT);
		if (!data_success) begin
			other_errors++;
			$display("%s: no data_success for address %h after %0d cycles", name, addr, cycles);
		end else if (wr) begin
			// Zero mask means both lanes
			if (mask == 2'b00 || mask[1])
				model[addr][BITS-1:LANE] = wdata[BITS-1:LANE];
			if (mask == 2'b00 || mask[0])
				model[addr][LANE-1:0] = wdata[LANE-1:0];
		end else begin
			check(name, model[addr], data_rdata);
		end
		data_read_req  = 1'b0;
		data_write_req = 1'b0;
	endtask

	// Collects fetch_valid pulses, addresses must be consecutive
	task automatic follow_fetches(input string name, input logic [AW-1:0] first,
		input int count);
		logic [AW-1:0] expected;
		int got;
		int cycles;
		expected = first;
		got = 0;
		cycles = 0;
		while (got < count && cycles < count * REQ_TIMEOUT) begin
			@(negedge CLK);
			cycles++;
			if (fetch_valid) begin
				check({name, " addr"}, expected, fetch_addr);
				check({name, " word"}, model[expected], fetch_word);
				expected++;
				got++;
			end
		end
		if (got < count) begin
			other_errors++;
			$display("%s: only %0d of %0d fetches arrived", name, got, count);
		end
	endtask

	task automatic idle_after_reset();
		repeat (16) begin
			@(negedge CLK);
			check("reset bank_sw", 0, bank_sw);
			check("reset fetch_valid", 0, fetch_valid);
			check("reset data_success", 0, data_success);
		end
	endtask

	task automatic write_read_back();
		logic [AW-1:0] addrs [16];
		bank_sw_seen = 1'b0;
		for (int i = 0; i < 16; i++) begin
			addrs[i] = AW'($urandom & 32'h3fff);
			access("write_read wr", 1'b1, addrs[i], BITS'($urandom), 2'b00);
		end
		for (int i = 0; i < 16; i++)
			access("write_read rd", 1'b0, addrs[i], '0, 2'b00);
		// All accesses in bank 0, no switch expected
		check("write_read bank_sw", 0, bank_sw_seen);
	endtask

	task automatic masked_writes();
		logic [AW-1:0] addr;
		wr_mask_t mask;
		for (int i = 0; i < 8; i++) begin
			addr = AW'($urandom & 32'h3fff);
			mask = ($urandom & 1) ? 2'b10 : 2'b01;
			access("mask full wr", 1'b1, addr, BITS'($urandom), 2'b00);
			access("mask lane wr", 1'b1, addr, BITS'($urandom), mask);
			access("mask rd", 1'b0, addr, '0, 2'b00);
		end
	endtask

	task automatic alternate_banks();
		logic [AW-1:0] addrs [8];
		bank_sw_seen = 1'b0;
		// Even index in bank 0, odd index in bank 1
		for (int i = 0; i < 8; i++) begin
			addrs[i] = {i[0], (AW-1)'($urandom)};
			access("bank_switch wr", 1'b1, addrs[i], BITS'($urandom), 2'b00);
		end
		for (int i = 0; i < 8; i++)
			access("bank_switch rd", 1'b0, addrs[i], '0, 2'b00);
		check("bank_sw seen", 1, bank_sw_seen);
	endtask

	task automatic fetch_sequence();
		for (int a = 'h100; a < 'h140; a++)
			access("fetch preload", 1'b1, AW'(a), BITS'($urandom), 2'b00);
		@(negedge CLK);
		start_address = AW'('h100);
		@(negedge CLK);
		fetch_en = 1'b1;
		follow_fetches("fetch", AW'('h100), 16);
		fetch_en = 1'b0;
		repeat (8) @(negedge CLK);
	endtask

	task automatic data_priority();
		@(negedge CLK);
		start_address = AW'('h120);
		@(negedge CLK);
		fetch_en = 1'b1;
		fork
			follow_fetches("priority fetch", AW'('h120), 16);
			begin
				repeat (6) @(negedge CLK);
				access("priority data rd", 1'b0, AW'('h105), '0, 2'b00);
			end
		join
		fetch_en = 1'b0;
		repeat (8) @(negedge CLK);
	endtask

	// Bound on the whole run
	initial begin
		repeat (N_TESTS * TEST_CYCLES) @(posedge CLK);
		$display("Watchdog expired after %0d cycles, tests did not finish",
			N_TESTS * TEST_CYCLES);
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		int assert_errors;
		void'($urandom(32'h82142bc4));
		check_errors = 0;
		other_errors = 0;
		bank_sw_seen = 1'b0;
		RSTb = 1'b0;
		fetch_en = 1'b0;
		start_address = '0;
		data_address = '0;
		data_wdata = '0;
		data_read_req = 1'b0;
		data_write_req = 1'b0;
		data_wr_mask = 2'b00;
		repeat (8) @(negedge CLK);
		RSTb = 1'b1;
		idle_after_reset();
		write_read_back();
		masked_writes();
		alternate_banks();
		fetch_sequence();
		data_priority();
		assert_errors = u_dut.u_arb.u_asserts.fail_count;
		$display("Errors: %0d check, %0d protocol, %0d assertion",
			check_errors, other_errors, assert_errors);
		if (check_errors + other_errors + assert_errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

//--- vlog.f
mem_bus_pkg.sv
mem_arb_pkg.sv
fetch_unit.sv
cpu_memory_interface.sv
bank_memory.sv
memory_subsystem_top.sv
tb_memory_subsystem_asserts.sv
tb_memory_subsystem.sv
